// ==== logic/core_pkg.sv ====
package core_pkg;

    // instruction address as seen by the fetch and execute stages
    localparam int addr_width = 32;

    typedef logic [addr_width-1:0] addr_t;

endpackage

// ==== logic/bht_pkg.sv ====
package bht_pkg;

    // stored tag is pc[2] plus the address bits above the set index
    localparam int tag_width = 18;

    typedef logic [tag_width-1:0] tag_t;

    // 2-bit saturating direction counter whose msb predicts taken
    typedef logic [1:0] counter_t;

    localparam counter_t counter_strong_not_taken = 2'b00;
    localparam counter_t counter_strong_taken = 2'b11;

    // init sweep FSM
    typedef enum logic [1:0] {
        sweep_idle,
        sweep_run,
        sweep_done
    } sweep_state_t;

    // one step toward the resolved outcome, saturating at both ends
    function automatic counter_t counter_step(counter_t cnt, logic taken);
        counter_t next;
        if (taken) begin
            if (cnt == counter_strong_taken) begin
                next = cnt;
            end else begin
                next = cnt + 2'd1;
            end
        end else begin
            if (cnt == counter_strong_not_taken) begin
                next = cnt;
            end else begin
                next = cnt - 2'd1;
            end
        end
        return next;
    endfunction

endpackage

// ==== logic/lutram_dual_port.sv ====
`timescale 1ns/1ps

module lutram_dual_port #(
    parameter int addr_width = 4,
    parameter int data_width = 32,
    parameter int byte_width = 8
) (
    input  logic                               clk,
    input  logic                               write_en,
    input  logic [addr_width-1:0]              addr_1,
    input  logic [data_width-1:0]              wdata,
    input  logic [data_width/byte_width-1:0]   strobe,
    output logic [data_width-1:0]              rdata_1,
    input  logic [addr_width-1:0]              addr_2,
    output logic [data_width-1:0]              rdata_2
);

    localparam int byte_num = data_width / byte_width;
    localparam int depth = 2 ** addr_width;

    logic [data_width-1:0] mem [depth];

    // port 1 writes only the lanes selected by strobe
    always_ff @(posedge clk) begin
        if (write_en) begin
            for (int i = 0; i < byte_num; i++) begin
                if (strobe[i]) begin
                    mem[addr_1][i*byte_width +: byte_width] <= wdata[i*byte_width +: byte_width];
                end
            end
        end
    end

    // both ports read without a clock
    assign rdata_1 = mem[addr_1];
    assign rdata_2 = mem[addr_2];

    // lanes must tile the word exactly or strobes would leave bits unwritable
    assert property (@(posedge clk) (data_width % byte_width) == 0)
        else $error("data_width %0d is not a multiple of byte_width %0d",
                    data_width, byte_width);

endmodule

// ==== logic/plru_tree.sv ====
`timescale 1ns/1ps

module plru_tree #(
    parameter int associativity = 2,
    parameter int set_num = 8,
    localparam int index_bits = $clog2(set_num),
    localparam int way_bits = $clog2(associativity)
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  touch_en,
    input  logic [index_bits-1:0] touch_index,
    input  logic [way_bits-1:0]   touch_way,
    input  logic [index_bits-1:0] victim_index,
    output logic [way_bits-1:0]   victim_way
);

    // node n has children 2n+1 (bit 0) and 2n+2 (bit 1) in heap order
    localparam int node_num = associativity - 1;

    typedef logic [node_num-1:0] tree_t;

    tree_t tree_q [set_num];
    tree_t touch_tree;

    // walk from the root along the touched way, pointing each node the other way
    always_comb begin
        int node;
        logic branch;
        touch_tree = tree_q[touch_index];
        node = 0;
        for (int lvl = 0; lvl < way_bits; lvl++) begin
            branch = touch_way[way_bits-1-lvl];
            touch_tree[node] = ~branch;
            node = 2 * node + 1 + int'(branch);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < set_num; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch_en) begin
            tree_q[touch_index] <= touch_tree;
        end
    end

    // victim follows the node bits down from the root
    // reads the registered state, so a same-cycle touch is not seen
    always_comb begin
        int node;
        tree_t cur;
        cur = tree_q[victim_index];
        node = 0;
        victim_way = '0;
        for (int lvl = 0; lvl < way_bits; lvl++) begin
            victim_way[way_bits-1-lvl] = cur[node];
            node = 2 * node + 1 + int'(cur[node]);
        end
    end

    // the lookup side must present a clean set index whenever it touches
    assert property (@(posedge clk) disable iff (!arst_n)
        touch_en |-> !$isunknown(touch_index))
        else $error("plru touch with unknown index");

endmodule

// ==== logic/bht_init_sweep.sv ====
`timescale 1ns/1ps

module bht_init_sweep #(
    parameter int associativity = 2,
    parameter int set_num = 8,
    localparam int index_bits = $clog2(set_num),
    localparam int way_bits = $clog2(associativity)
) (
    input  logic                  clk,
    input  logic                  arst_n,
    output logic                  sweep_active,
    output logic [index_bits-1:0] sweep_addr_index,
    output logic [way_bits-1:0]   sweep_addr_way,
    output logic                  ready
);

    import bht_pkg::*;

    localparam int entry_num = set_num * associativity;
    localparam int count_bits = index_bits + way_bits;

    sweep_state_t state;
    sweep_state_t state_next;
    logic [count_bits-1:0] count;
    logic last;

    // entry 0 is already written on the edge that leaves idle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= sweep_idle;
            count <= '0;
        end else begin
            state <= state_next;
            if (sweep_active) begin
                count <= count + 1'b1;
            end
        end
    end

    assign last = (count == count_bits'(entry_num - 1));

    always_comb begin
        state_next = state;
        unique case (state)
            sweep_idle: state_next = last ? sweep_done : sweep_run;
            sweep_run:  state_next = last ? sweep_done : sweep_run;
            default:    state_next = sweep_done;
        endcase
    end

    assign sweep_active = (state != sweep_done);
    assign ready = (state == sweep_done);

    // count is {index, way} with the way in the low bits
    assign sweep_addr_index = count[count_bits-1 -: index_bits];
    assign sweep_addr_way = count[way_bits-1:0];

    // once the table is clean it stays usable until the next reset
    assert property (@(posedge clk) disable iff (!arst_n) ready |=> ready)
        else $error("ready dropped after init sweep");

endmodule

// ==== logic/bht.sv ====
`timescale 1ns/1ps

module bht #(
    parameter int associativity = 2,
    parameter int set_num = 8,
    localparam int index_bits = $clog2(set_num),
    localparam int way_bits = $clog2(associativity)
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  core_pkg::addr_t       fetch_pc,
    input  logic                  train_valid,
    input  core_pkg::addr_t       train_pc,
    input  core_pkg::addr_t       train_target,
    input  logic                  train_taken,
    input  logic                  sweep_active,
    input  logic [index_bits-1:0] sweep_addr_index,
    input  logic [way_bits-1:0]   sweep_addr_way,
    output logic                  hit,
    output logic                  hit_pc,
    output logic                  hit_pcp4,
    output logic                  predict_taken,
    output core_pkg::addr_t       predict_target
);

    import core_pkg::*;
    import bht_pkg::*;

    // meta entry is {valid, tag}
    localparam int meta_width = 1 + tag_width;
    localparam int entry_bits = index_bits + way_bits;

    typedef logic [index_bits-1:0] index_t;
    typedef logic [way_bits-1:0] way_t;
    typedef logic [meta_width-1:0] meta_t;
    typedef logic [entry_bits-1:0] entry_t;

    index_t fetch_index;
    tag_t tag_pc;
    tag_t tag_pcp4;
    meta_t [associativity-1:0] fetch_meta;
    logic pc_match;
    logic pcp4_match;
    way_t pc_way;
    way_t pcp4_way;
    way_t hit_way;
    entry_t rd_entry;
    addr_t fetch_target;
    counter_t fetch_counter;

    index_t train_index;
    tag_t train_tag;
    meta_t [associativity-1:0] train_meta;
    logic train_match;
    way_t train_way;
    way_t victim_way;
    counter_t train_counter;
    logic do_step;
    logic do_alloc;

    index_t wr_index;
    way_t wr_way;
    entry_t wr_entry;
    logic [associativity-1:0] way_strobe;
    meta_t [associativity-1:0] meta_wdata;
    addr_t target_wdata;
    counter_t counter_wdata;
    logic dup_tag;

    // index sits above bit 3 so pc and pc+4 share a set, bit 2 goes in the tag
    function automatic index_t get_index(addr_t pc);
        return pc[3 +: index_bits];
    endfunction

    function automatic tag_t get_tag(addr_t pc);
        return {pc[3 + index_bits +: tag_width - 1], pc[2]};
    endfunction

    function automatic logic entry_matches(meta_t m, tag_t t);
        return m[meta_width-1] && (m[tag_width-1:0] == t);
    endfunction

    // lookup side
    assign fetch_index = get_index(fetch_pc);
    assign tag_pc = get_tag(fetch_pc);
    assign tag_pcp4 = get_tag(fetch_pc + addr_t'(4));

    always_comb begin
        pc_match = 1'b0;
        pc_way = '0;
        pcp4_match = 1'b0;
        pcp4_way = '0;
        for (int w = 0; w < associativity; w++) begin
            if (entry_matches(fetch_meta[w], tag_pc)) begin
                pc_match = 1'b1;
                pc_way = way_t'(w);
            end
            if (entry_matches(fetch_meta[w], tag_pcp4)) begin
                pcp4_match = 1'b1;
                pcp4_way = way_t'(w);
            end
        end
    end

    // the earlier slot wins when both hold a branch
    assign hit_way = pc_match ? pc_way : pcp4_way;
    assign rd_entry = {fetch_index, hit_way};

    assign hit = pc_match | pcp4_match;
    assign hit_pc = pc_match;
    assign hit_pcp4 = pcp4_match;
    assign predict_taken = hit & fetch_counter[1];
    assign predict_target = hit ? fetch_target : '0;

    // training side
    assign train_index = get_index(train_pc);
    assign train_tag = get_tag(train_pc);

    always_comb begin
        train_match = 1'b0;
        train_way = '0;
        for (int w = 0; w < associativity; w++) begin
            if (entry_matches(train_meta[w], train_tag)) begin
                train_match = 1'b1;
                train_way = way_t'(w);
            end
        end
    end

    // a not-taken miss falls through both and is dropped
    assign do_step = train_valid & ~sweep_active & train_match;
    assign do_alloc = train_valid & ~sweep_active & ~train_match & train_taken;

    // port 1 of every table is shared by the sweep and training
    assign wr_index = sweep_active ? sweep_addr_index : train_index;

    always_comb begin
        if (sweep_active) begin
            wr_way = sweep_addr_way;
        end else if (train_match) begin
            wr_way = train_way;
        end else begin
            wr_way = victim_way;
        end
    end

    assign wr_entry = {wr_index, wr_way};
    assign way_strobe = {{(associativity-1){1'b0}}, 1'b1} << wr_way;

    always_comb begin
        for (int w = 0; w < associativity; w++) begin
            meta_wdata[w] = sweep_active ? meta_t'(0) : {1'b1, train_tag};
        end
    end

    assign target_wdata = sweep_active ? '0 : train_target;
    assign counter_wdata = do_step ? counter_step(train_counter, train_taken)
                                   : counter_strong_taken;

    // one word per set, one strobe lane per way
    lutram_dual_port #(
        .addr_width (index_bits),
        .data_width (associativity * meta_width),
        .byte_width (meta_width)
    ) meta_ram (
        .clk      (clk),
        .write_en (sweep_active | do_alloc),
        .addr_1   (wr_index),
        .wdata    (meta_wdata),
        .strobe   (way_strobe),
        .rdata_1  (train_meta),
        .addr_2   (fetch_index),
        .rdata_2  (fetch_meta)
    );

    // targets are written on allocation only
    lutram_dual_port #(
        .addr_width (entry_bits),
        .data_width (addr_width),
        .byte_width (addr_width)
    ) target_ram (
        .clk      (clk),
        .write_en (sweep_active | do_alloc),
        .addr_1   (wr_entry),
        .wdata    (target_wdata),
        .strobe   (1'b1),
        .rdata_1  (),
        .addr_2   (rd_entry),
        .rdata_2  (fetch_target)
    );

    lutram_dual_port #(
        .addr_width (entry_bits),
        .data_width ($bits(counter_t)),
        .byte_width ($bits(counter_t))
    ) counter_ram (
        .clk      (clk),
        .write_en (sweep_active | do_alloc | do_step),
        .addr_1   (wr_entry),
        .wdata    (counter_wdata),
        .strobe   (1'b1),
        .rdata_1  (train_counter),
        .addr_2   (rd_entry),
        .rdata_2  (fetch_counter)
    );

    plru_tree #(
        .associativity (associativity),
        .set_num       (set_num)
    ) plru_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .touch_en     (hit & ~sweep_active),
        .touch_index  (fetch_index),
        .touch_way    (hit_way),
        .victim_index (train_index),
        .victim_way   (victim_way)
    );

    // allocation only happens on a miss, so a set never holds a tag twice
    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < associativity; i++) begin
            for (int j = i + 1; j < associativity; j++) begin
                if (fetch_meta[i][meta_width-1] && fetch_meta[j][meta_width-1] &&
                    fetch_meta[i][tag_width-1:0] == fetch_meta[j][tag_width-1:0]) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n || sweep_active) !dup_tag)
        else $error("duplicate tag in set %0d", fetch_index);

endmodule

// ==== logic/fetch_predictor.sv ====
`timescale 1ns/1ps

module fetch_predictor #(
    parameter int associativity = 2,
    parameter int set_num = 8
) (
    input  logic            clk,
    input  logic            arst_n,
    input  core_pkg::addr_t fetch_pc,
    input  logic            train_valid,
    input  core_pkg::addr_t train_pc,
    input  core_pkg::addr_t train_target,
    input  logic            train_taken,
    output logic            ready,
    output logic            hit,
    output logic            hit_pc,
    output logic            hit_pcp4,
    output logic            predict_taken,
    output core_pkg::addr_t predict_target,
    output core_pkg::addr_t next_fetch_pc
);

    import core_pkg::*;

    localparam int index_bits = $clog2(set_num);
    localparam int way_bits = $clog2(associativity);

    logic sweep_active;
    logic [index_bits-1:0] sweep_addr_index;
    logic [way_bits-1:0] sweep_addr_way;
    logic bht_hit;
    logic bht_hit_pc;
    logic bht_hit_pcp4;
    logic bht_predict_taken;
    addr_t bht_predict_target;

    bht_init_sweep #(
        .associativity (associativity),
        .set_num       (set_num)
    ) sweep_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .sweep_active     (sweep_active),
        .sweep_addr_index (sweep_addr_index),
        .sweep_addr_way   (sweep_addr_way),
        .ready            (ready)
    );

    // trainings that arrive before the table is clean are dropped
    bht #(
        .associativity (associativity),
        .set_num       (set_num)
    ) bht_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .fetch_pc         (fetch_pc),
        .train_valid      (train_valid & ready),
        .train_pc         (train_pc),
        .train_target     (train_target),
        .train_taken      (train_taken),
        .sweep_active     (sweep_active),
        .sweep_addr_index (sweep_addr_index),
        .sweep_addr_way   (sweep_addr_way),
        .hit              (bht_hit),
        .hit_pc           (bht_hit_pc),
        .hit_pcp4         (bht_hit_pcp4),
        .predict_taken    (bht_predict_taken),
        .predict_target   (bht_predict_target)
    );

    // table contents are meaningless until the sweep finishes
    assign hit = ready & bht_hit;
    assign hit_pc = ready & bht_hit_pc;
    assign hit_pcp4 = ready & bht_hit_pcp4;
    assign predict_taken = ready & bht_predict_taken;
    assign predict_target = ready ? bht_predict_target : '0;

    // fall through to the next packet unless a hit predicts taken
    assign next_fetch_pc = (hit & predict_taken) ? predict_target : fetch_pc + addr_t'(8);

endmodule

// ==== verification/tb_fetch_predictor.sv ====
`timescale 1ns/1ps

module tb_fetch_predictor #(
    parameter int associativity = 2,
    parameter int set_num = 8
);

    import core_pkg::*;

    localparam int way_bits = $clog2(associativity);
    localparam int field_num = 11;
    localparam int pattern_num = 21;
    localparam int ready_timeout = 200;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    // set 7 is never trained, so lookups there never touch the PLRU
    localparam addr_t idle_pc = 32'h0000_0038;
    localparam addr_t random_pc = 32'h0000_6030;
    localparam addr_t random_target = 32'h0000_7000;

    logic clk = 1'b0;
    logic arst_n;
    addr_t fetch_pc;
    logic train_valid;
    addr_t train_pc;
    addr_t train_target;
    logic train_taken;
    logic ready;
    logic hit;
    logic hit_pc;
    logic hit_pcp4;
    logic predict_taken;
    addr_t predict_target;
    addr_t next_fetch_pc;

    logic [31:0] pattern_mem [field_num*pattern_num];
    logic [31:0] lfsr_state = 32'haaaa_989a;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic ready_ok;

    // reference PLRU state of the replacement set, and where each branch lives
    logic [associativity-2:0] plru_bits;
    int way_of [associativity];

    fetch_predictor #(
        .associativity (associativity),
        .set_num       (set_num)
    ) dut_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .fetch_pc       (fetch_pc),
        .train_valid    (train_valid),
        .train_pc       (train_pc),
        .train_target   (train_target),
        .train_taken    (train_taken),
        .ready          (ready),
        .hit            (hit),
        .hit_pc         (hit_pc),
        .hit_pcp4       (hit_pcp4),
        .predict_taken  (predict_taken),
        .predict_target (predict_target),
        .next_fetch_pc  (next_fetch_pc)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] value;
        logic lsb;
        value = '0;
        for (int k = 0; k < n; k++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ lfsr_taps;
            end
            value = {value[30:0], lsb};
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    // lookup outputs are sampled just before the next edge
    task automatic apply_lookup(input addr_t pc);
        next_cycle();
        train_valid = 1'b0;
        fetch_pc = pc;
        #3;
    endtask

    task automatic apply_train(input addr_t pc, input addr_t target, input logic taken);
        next_cycle();
        fetch_pc = idle_pc;
        train_valid = 1'b1;
        train_pc = pc;
        train_target = target;
        train_taken = taken;
    endtask

    task automatic check_lookup(input logic exp_hit, input logic exp_hit_pc,
                                input logic exp_hit_pcp4, input logic exp_taken,
                                input addr_t exp_target, input addr_t exp_next);
        check_value("hit", hit, exp_hit);
        check_value("hit_pc", hit_pc, exp_hit_pc);
        check_value("hit_pcp4", hit_pcp4, exp_hit_pcp4);
        check_value("predict_taken", predict_taken, exp_taken);
        if (exp_hit) begin
            check_value("predict_target", predict_target, exp_target);
        end
        check_value("next_fetch_pc", next_fetch_pc, exp_next);
    endtask

    // saturating 2-bit direction counter
    function automatic logic [1:0] next_count(input logic [1:0] cnt, input logic up);
        if (up) begin
            return (cnt == 2'b11) ? cnt : cnt + 2'b01;
        end
        return (cnt == 2'b00) ? cnt : cnt - 2'b01;
    endfunction

    function automatic int model_victim();
        int node;
        int way;
        node = 0;
        way = 0;
        for (int lvl = 0; lvl < way_bits; lvl++) begin
            way = 2 * way + int'(plru_bits[node]);
            node = 2 * node + 1 + int'(plru_bits[node]);
        end
        return way;
    endfunction

    // every node on the path points away from the touched way
    task automatic model_touch(input int way);
        int node;
        int dir;
        node = 0;
        for (int lvl = way_bits - 1; lvl >= 0; lvl--) begin
            dir = (way >> lvl) & 1;
            plru_bits[node] = (dir == 0);
            node = 2 * node + 1 + dir;
        end
    endtask

    function automatic addr_t repl_pc(input int i);
        return addr_t'(32'h0020_0028 + i * 32'h100);
    endfunction

    function automatic addr_t repl_target(input int i);
        return addr_t'(32'h0090_0000 + i * 32'h40);
    endfunction

    function automatic string group_name(input int group);
        case (group)
            2: return "untrained and not-taken miss";
            3: return "taken allocation";
            4: return "counter stepping";
            5: return "slot priority";
            default: return $sformatf("pattern group %0d", group);
        endcase
    endfunction

    // lookups and dropped trainings while the sweep runs
    task automatic run_ready_test(output logic ok);
        int cycles;
        int errors_before;
        logic [31:0] r;
        addr_t pc;
        errors_before = errors;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles <= ready_timeout) begin
            r = draw_bits(32);
            pc = {r[31:3], 3'b000};
            fetch_pc = pc;
            train_valid = (cycles < 4);
            train_pc = 32'h0000_1000;
            train_target = 32'h0000_2040;
            train_taken = 1'b1;
            #3;
            if (ready) begin
                ok = 1'b1;
            end else begin
                check_lookup(1'b0, 1'b0, 1'b0, 1'b0, '0, pc + 32'd8);
                next_cycle();
                cycles++;
            end
        end
        if (ok) begin
            check_value("ready delay in cycles", cycles, set_num * associativity);
        end else begin
            errors++;
            $display("ready did not rise within %0d cycles after reset", ready_timeout);
        end
        finish_test("reset sweep and ready", errors_before);
    endtask

    task automatic run_pattern_tests();
        int errors_before;
        int group;
        int base;
        group = -1;
        errors_before = errors;
        for (int i = 0; i < pattern_num; i++) begin
            base = i * field_num;
            if (int'(pattern_mem[base]) != group) begin
                if (group >= 0) begin
                    finish_test(group_name(group), errors_before);
                end
                group = int'(pattern_mem[base]);
                errors_before = errors;
            end
            case (pattern_mem[base+1])
                32'd1: begin
                    apply_lookup(pattern_mem[base+2]);
                    check_lookup(pattern_mem[base+5][0], pattern_mem[base+6][0],
                                 pattern_mem[base+7][0], pattern_mem[base+8][0],
                                 pattern_mem[base+9], pattern_mem[base+10]);
                end
                32'd2: begin
                    apply_train(pattern_mem[base+2], pattern_mem[base+3],
                                pattern_mem[base+4][0]);
                end
                default: begin
                    errors++;
                    $display("pattern line %0d has an unknown operation code", i);
                end
            endcase
        end
        finish_test(group_name(group), errors_before);
    endtask

    task automatic run_random_counter_test();
        int errors_before;
        logic [1:0] model;
        logic [31:0] r;
        errors_before = errors;
        apply_train(random_pc, random_target, 1'b1);
        model = 2'b11;
        apply_lookup(random_pc);
        check_lookup(1'b1, 1'b1, 1'b0, 1'b1, random_target, random_target);
        repeat (16) begin
            r = draw_bits(1);
            apply_train(random_pc, random_target, r[0]);
            model = next_count(model, r[0]);
            apply_lookup(random_pc);
            check_lookup(1'b1, 1'b1, 1'b0, model[1], random_target,
                         model[1] ? random_target : random_pc + 32'd8);
        end
        finish_test("random counter sequence", errors_before);
    endtask

    task automatic run_replacement_test();
        int errors_before;
        int victim;
        int evicted;
        int pick;
        logic [31:0] r;
        errors_before = errors;
        plru_bits = '0;
        // each new branch is looked up once so the next allocation moves on
        for (int i = 0; i < associativity; i++) begin
            victim = model_victim();
            way_of[i] = victim;
            apply_train(repl_pc(i), repl_target(i), 1'b1);
            apply_lookup(repl_pc(i));
            check_lookup(1'b1, 1'b1, 1'b0, 1'b1, repl_target(i), repl_target(i));
            model_touch(victim);
        end
        for (int k = 0; k < 2 * associativity; k++) begin
            r = draw_bits(way_bits);
            pick = int'(r);
            apply_lookup(repl_pc(pick));
            check_lookup(1'b1, 1'b1, 1'b0, 1'b1, repl_target(pick), repl_target(pick));
            model_touch(way_of[pick]);
        end
        victim = model_victim();
        evicted = -1;
        for (int i = 0; i < associativity; i++) begin
            if (way_of[i] == victim) begin
                evicted = i;
            end
        end
        if (evicted < 0) begin
            errors++;
            $display("model victim way %0d holds none of the filled branches", victim);
        end
        apply_train(repl_pc(associativity), repl_target(associativity), 1'b1);
        for (int i = 0; i <= associativity; i++) begin
            apply_lookup(repl_pc(i));
            if (i == evicted) begin
                check_lookup(1'b0, 1'b0, 1'b0, 1'b0, '0, repl_pc(i) + 32'd8);
            end else begin
                check_lookup(1'b1, 1'b1, 1'b0, 1'b1, repl_target(i), repl_target(i));
            end
        end
        finish_test("plru replacement", errors_before);
    endtask

    task automatic print_summary();
        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
    endtask

    initial begin
        arst_n = 1'b0;
        fetch_pc = idle_pc;
        train_valid = 1'b0;
        train_pc = '0;
        train_target = '0;
        train_taken = 1'b0;
        $readmemh("verification/predictor_patterns.hex", pattern_mem);
        repeat (3) @(posedge clk);
        #0.5;
        arst_n = 1'b1;
        run_ready_test(ready_ok);
        if (!ready_ok) begin
            print_summary();
            $display("CHECKS FAILED");
            $finish;
        end else begin
            run_pattern_tests();
            run_random_counter_test();
            run_replacement_test();
            next_cycle();
            print_summary();
            if (errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== verification/predictor_patterns.hex ====
// columns: group op pc target taken | hit hit_pc hit_pcp4 predict_taken predict_target next_pc
// op 1 is a lookup of pc, op 2 trains pc with target and taken; expected columns unused for op 2
// group 2, untrained pcs and a not-taken training of an absent branch all miss
2 1 00001000 00000000 0 0 0 0 0 00000000 00001008
2 1 00001008 00000000 0 0 0 0 0 00000000 00001010
2 2 00001000 00002040 0 0 0 0 0 00000000 00000000
2 1 00001000 00000000 0 0 0 0 0 00000000 00001008
2 2 00003010 00005500 0 0 0 0 0 00000000 00000000
2 1 00003010 00000000 0 0 0 0 0 00000000 00003018
// group 3, a taken training allocates the branch
3 2 00001000 00002040 1 0 0 0 0 00000000 00000000
3 1 00001000 00000000 0 1 1 0 1 00002040 00002040
// group 4, counter steps from strongly taken down and back up
4 2 00001000 00002040 0 0 0 0 0 00000000 00000000
4 1 00001000 00000000 0 1 1 0 1 00002040 00002040
4 2 00001000 00002040 0 0 0 0 0 00000000 00000000
4 1 00001000 00000000 0 1 1 0 0 00002040 00001008
4 2 00001000 00002040 1 0 0 0 0 00000000 00000000
4 1 00001000 00000000 0 1 1 0 1 00002040 00002040
// group 5, pc+4 alone, then both slots where pc wins
5 2 00003014 00004400 1 0 0 0 0 00000000 00000000
5 1 00003010 00000000 0 1 0 1 1 00004400 00004400
5 2 00003010 00005500 1 0 0 0 0 00000000 00000000
5 1 00003010 00000000 0 1 1 1 1 00005500 00005500
5 2 00003010 00005500 0 0 0 0 0 00000000 00000000
5 2 00003010 00005500 0 0 0 0 0 00000000 00000000
5 1 00003010 00000000 0 1 1 1 0 00005500 00003018

// ==== sources.f ====
logic/core_pkg.sv
logic/bht_pkg.sv
logic/lutram_dual_port.sv
logic/plru_tree.sv
logic/bht_init_sweep.sv
logic/bht.sv
logic/fetch_predictor.sv
verification/tb_fetch_predictor.sv
